/* Bender.yml */
package:
  name: video_mnist_color

sources:
  - target: any(simulation, synthesis)
    files:
      - design/video_pkg.sv
      - design/mnist_pkg.sv
      - design/stream_fifo.sv
      - design/video_binarizer.sv
      - design/video_mnist_color_core.sv
      - design/video_mnist_color.sv
  - target: simulation
    files:
      - testbench/tb_video_mnist_color.sv

/* design/mnist_pkg.sv */
// ------------------------------------------------------------
// digit label constants: label widths, mode bit indices
// and the resistor-code color table
// ------------------------------------------------------------

`default_nettype none

package mnist_pkg;

	// label fields from the classifier
	localparam int number_width = 4;	// 0..15, only 0..9 meaningful
	localparam int count_width  = 2;	// confidence count
	localparam int digit_num    = 10;

	// param_mode bit positions
	localparam int mode_binary  = 0;	// flag instead of pixel
	localparam int mode_overlay = 1;	// paint confident pixels

	// ------------------------------------------------------------
	// resistor color code, already in stream channel order
	// (channel 2 in the high byte)
	// ------------------------------------------------------------
	localparam logic [video_pkg::pixel_width-1:0] color_table [digit_num] = '{
		24'h00_00_00,	// 0 black
		24'h80_00_00,	// 1 brown
		24'hff_00_00,	// 2 red
		24'hff_b7_4c,	// 3 orange
		24'hff_ff_00,	// 4 yellow
		24'h00_80_00,	// 5 green
		24'h00_00_ff,	// 6 blue
		24'h80_00_80,	// 7 violet
		24'h80_80_80,	// 8 gray
		24'hff_ff_ff	// 9 white
	};

endpackage

`default_nettype wire

/* design/stream_fifo.sv */
// ------------------------------------------------------------
// stream_fifo: synchronous show-ahead FIFO, valid/ready on
// both sides, payload given as a type parameter
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 16
) (
	input  wire           aclk,
	input  wire           aresetn,

	input  wire payload_t in_tdata,
	input  wire           in_tvalid,
	output logic          in_tready,

	output payload_t      out_tdata,
	output logic          out_tvalid,
	input  wire           out_tready
);

	payload_t                   mem [depth];
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic                       full;
	logic                       wr_en;
	logic                       rd_en;

	assign full  = (count == depth);
	assign wr_en = in_tvalid && in_tready;
	assign rd_en = out_tvalid && out_tready;

	// a full FIFO still takes a beat when one leaves
	assign in_tready  = !full || out_tready;
	assign out_tvalid = (count != 0);
	assign out_tdata  = mem[rd_ptr];	// show-ahead read

	// storage
	always_ff @(posedge aclk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_tdata;
		end
	end

	// ------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// idle or both
			endcase
		end
	end

	// occupancy bounded by depth and consistent with the pointers
	a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
		(count <= depth) && (!full || (wr_ptr == rd_ptr)));

	// stalled head beat stays put
	a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		(out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)));

endmodule

`default_nettype wire

/* design/video_binarizer.sv */
// ------------------------------------------------------------
// video_binarizer: luma and one-bit foreground flag,
// one register stage, labels carried alongside
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module video_binarizer (
	input  wire                                   aclk,
	input  wire                                   aresetn,
	input  wire  [video_pkg::chan_width-1:0]      param_bin_th,

	input  wire  [video_pkg::user_width-1:0]      s_tuser,
	input  wire                                   s_tlast,
	input  wire  [video_pkg::pixel_width-1:0]     s_tdata,
	input  wire  [mnist_pkg::number_width-1:0]    s_tnumber,
	input  wire  [mnist_pkg::count_width-1:0]     s_tcount,
	input  wire                                   s_tvalid,
	output logic                                  s_tready,

	output logic [video_pkg::user_width-1:0]      m_tuser,
	output logic                                  m_tlast,
	output logic [video_pkg::pixel_width-1:0]     m_tdata,
	output logic [mnist_pkg::number_width-1:0]    m_tnumber,
	output logic [mnist_pkg::count_width-1:0]     m_tcount,
	output logic                                  m_tbinary,
	output logic                                  m_tvalid,
	input  wire                                   m_tready
);

	logic [video_pkg::chan_width+1:0] luma_sum;	// two guard bits
	logic [video_pkg::chan_width-1:0] luma;

	// (c0 + 2*c1 + c2) / 4
	assign luma_sum = {2'b00, s_tdata[0 +: video_pkg::chan_width]}
		+ {1'b0, s_tdata[video_pkg::chan_width +: video_pkg::chan_width], 1'b0}
		+ {2'b00, s_tdata[2*video_pkg::chan_width +: video_pkg::chan_width]};
	assign luma = luma_sum[video_pkg::chan_width+1:2];

	assign s_tready = m_tready || !m_tvalid;	// stage empty or draining

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			m_tvalid <= 1'b0;
		end else if (s_tready) begin
			m_tvalid <= s_tvalid;
		end
	end

	// payload, held while stalled
	always_ff @(posedge aclk) begin
		if (s_tready) begin
			m_tuser   <= s_tuser;
			m_tlast   <= s_tlast;
			m_tdata   <= s_tdata;
			m_tnumber <= s_tnumber;
			m_tcount  <= s_tcount;
			m_tbinary <= (luma >= param_bin_th);
		end
	end

	a_valid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && !m_tready) |=> m_tvalid);

endmodule

`default_nettype wire

/* design/video_mnist_color.sv */
// ------------------------------------------------------------
// video_mnist_color: input FIFO, binarizer, color core
// and output FIFO in a chain
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module video_mnist_color (
	input  wire                                   aclk,
	input  wire                                   aresetn,
	input  wire  [1:0]                            param_mode,
	input  wire  [mnist_pkg::count_width-1:0]     param_th,
	input  wire  [video_pkg::chan_width-1:0]      param_bin_th,

	input  wire  [video_pkg::user_width-1:0]      s_tuser,
	input  wire                                   s_tlast,
	input  wire  [video_pkg::pixel_width-1:0]     s_tdata,
	input  wire  [mnist_pkg::number_width-1:0]    s_tnumber,
	input  wire  [mnist_pkg::count_width-1:0]     s_tcount,
	input  wire                                   s_tvalid,
	output logic                                  s_tready,

	output logic [video_pkg::user_width-1:0]      m_tuser,
	output logic                                  m_tlast,
	output logic [video_pkg::pixel_width-1:0]     m_tdata,
	output logic                                  m_tvalid,
	input  wire                                   m_tready
);

	// payload vectors: tuser, tlast, tdata, then labels
	typedef logic [video_pkg::user_width + 1 + video_pkg::pixel_width
		+ mnist_pkg::number_width + mnist_pkg::count_width - 1:0] in_payload_t;
	typedef logic [video_pkg::user_width + 1 + video_pkg::pixel_width - 1:0] out_payload_t;

	in_payload_t                          fi_payload;
	logic [video_pkg::user_width-1:0]     fi_tuser;
	logic                                 fi_tlast;
	logic [video_pkg::pixel_width-1:0]    fi_tdata;
	logic [mnist_pkg::number_width-1:0]   fi_tnumber;
	logic [mnist_pkg::count_width-1:0]    fi_tcount;
	logic                                 fi_tvalid;
	logic                                 fi_tready;

	logic [video_pkg::user_width-1:0]     bc_tuser;
	logic                                 bc_tlast;
	logic [video_pkg::pixel_width-1:0]    bc_tdata;
	logic [mnist_pkg::number_width-1:0]   bc_tnumber;
	logic [mnist_pkg::count_width-1:0]    bc_tcount;
	logic                                 bc_tbinary;
	logic                                 bc_tvalid;
	logic                                 bc_tready;

	logic [video_pkg::user_width-1:0]     co_tuser;
	logic                                 co_tlast;
	logic [video_pkg::pixel_width-1:0]    co_tdata;
	logic                                 co_tvalid;
	logic                                 co_tready;

	out_payload_t                         fo_payload;

	assign {fi_tuser, fi_tlast, fi_tdata, fi_tnumber, fi_tcount} = fi_payload;
	assign {m_tuser, m_tlast, m_tdata} = fo_payload;

	stream_fifo #(.payload_t(in_payload_t), .depth(video_pkg::fifo_depth)) u_in_fifo (
		.aclk, .aresetn,
		.in_tdata  ({s_tuser, s_tlast, s_tdata, s_tnumber, s_tcount}),
		.in_tvalid (s_tvalid),  .in_tready (s_tready),
		.out_tdata (fi_payload), .out_tvalid (fi_tvalid), .out_tready (fi_tready)
	);

	video_binarizer u_binarizer (
		.aclk, .aresetn, .param_bin_th,
		.s_tuser (fi_tuser), .s_tlast (fi_tlast), .s_tdata (fi_tdata),
		.s_tnumber (fi_tnumber), .s_tcount (fi_tcount),
		.s_tvalid (fi_tvalid), .s_tready (fi_tready),
		.m_tuser (bc_tuser), .m_tlast (bc_tlast), .m_tdata (bc_tdata),
		.m_tnumber (bc_tnumber), .m_tcount (bc_tcount), .m_tbinary (bc_tbinary),
		.m_tvalid (bc_tvalid), .m_tready (bc_tready)
	);

	video_mnist_color_core u_core (
		.aclk, .aresetn, .param_mode, .param_th,
		.s_tuser (bc_tuser), .s_tlast (bc_tlast), .s_tdata (bc_tdata),
		.s_tnumber (bc_tnumber), .s_tcount (bc_tcount), .s_tbinary (bc_tbinary),
		.s_tvalid (bc_tvalid), .s_tready (bc_tready),
		.m_tuser (co_tuser), .m_tlast (co_tlast), .m_tdata (co_tdata),
		.m_tvalid (co_tvalid), .m_tready (co_tready)
	);

	// absorbs sink back-pressure
	stream_fifo #(.payload_t(out_payload_t), .depth(video_pkg::fifo_depth)) u_out_fifo (
		.aclk, .aresetn,
		.in_tdata  ({co_tuser, co_tlast, co_tdata}),
		.in_tvalid (co_tvalid),  .in_tready (co_tready),
		.out_tdata (fo_payload), .out_tvalid (m_tvalid), .out_tready (m_tready)
	);

endmodule

`default_nettype wire

/* design/video_mnist_color_core.sv */
// ------------------------------------------------------------
// video_mnist_color_core: binary or original base data,
// digit color overlay, two-stage pipeline
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module video_mnist_color_core (
	input  wire                                   aclk,
	input  wire                                   aresetn,
	input  wire  [1:0]                            param_mode,
	input  wire  [mnist_pkg::count_width-1:0]     param_th,

	input  wire  [video_pkg::user_width-1:0]      s_tuser,
	input  wire                                   s_tlast,
	input  wire  [video_pkg::pixel_width-1:0]     s_tdata,
	input  wire  [mnist_pkg::number_width-1:0]    s_tnumber,
	input  wire  [mnist_pkg::count_width-1:0]     s_tcount,
	input  wire                                   s_tbinary,
	input  wire                                   s_tvalid,
	output logic                                  s_tready,

	output logic [video_pkg::user_width-1:0]      m_tuser,
	output logic                                  m_tlast,
	output logic [video_pkg::pixel_width-1:0]     m_tdata,
	output logic                                  m_tvalid,
	input  wire                                   m_tready
);

	logic                                 digit_ok;
	logic [video_pkg::user_width-1:0]     st0_user;
	logic                                 st0_last;
	logic [video_pkg::pixel_width-1:0]    st0_data;
	logic [video_pkg::pixel_width-1:0]    st0_color;
	logic                                 st0_en;
	logic                                 st0_valid;

	assign digit_ok = (s_tnumber < mnist_pkg::digit_num);	// 10..15 never paint
	assign s_tready = m_tready || !m_tvalid;

	// ------------------------------------------------------------
	// valid chain, both stages move together
	// ------------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			st0_valid <= 1'b0;
			m_tvalid  <= 1'b0;
		end else if (s_tready) begin
			st0_valid <= s_tvalid;
			m_tvalid  <= st0_valid;
		end
	end

	// ------------------------------------------------------------
	// payload
	// ------------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (s_tready) begin
			// stage 0: base data and color lookup
			st0_user  <= s_tuser;
			st0_last  <= s_tlast;
			st0_data  <= param_mode[mnist_pkg::mode_binary]
				? {video_pkg::pixel_width{s_tbinary}} : s_tdata;
			st0_color <= digit_ok ? mnist_pkg::color_table[s_tnumber] : '0;
			st0_en    <= param_mode[mnist_pkg::mode_overlay]
				&& (s_tcount >= param_th) && digit_ok;

			// stage 1: overlay
			m_tuser <= st0_user;
			m_tlast <= st0_last;
			m_tdata <= st0_en ? st0_color : st0_data;
		end
	end

	// pipeline comes out of reset empty
	a_reset_empty: assert property (@(posedge aclk)
		!aresetn |=> !m_tvalid);

endmodule

`default_nettype wire

/* design/video_pkg.sv */
// ------------------------------------------------------------
// video stream constants: channel and pixel widths,
// tuser width and default FIFO depth
// ------------------------------------------------------------

`default_nettype none

package video_pkg;

	// ------------------------------------------------------------
	// pixel layout, channel 0 in the low byte
	// ------------------------------------------------------------
	localparam int chan_width  = 8;	// one word per channel
	localparam int chan_num    = 3;	// rgb only, no alpha
	localparam int pixel_width = chan_width * chan_num;

	// side band
	localparam int user_width = 1;	// start of frame

	// ------------------------------------------------------------
	// buffering
	// ------------------------------------------------------------
	localparam int fifo_depth = 16;	// used for input and output FIFO

endpackage

`default_nettype wire

/* list.f */
design/video_pkg.sv
design/mnist_pkg.sv
design/stream_fifo.sv
design/video_binarizer.sv
design/video_mnist_color_core.sv
design/video_mnist_color.sv
testbench/tb_video_mnist_color.sv

/* testbench/tb_video_mnist_color.sv */
// ------------------------------------------------------------
// testbench for video_mnist_color: LFSR stimulus, expected
// beat queue, assertion checks, watchdog and summary
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_video_mnist_color;

	localparam int beats_per_phase = 200;
	localparam int phase_num       = 5;
	localparam int total_beats     = beats_per_phase * phase_num;
	localparam int beat_width      = video_pkg::user_width + 1 + video_pkg::pixel_width;

	// resistor code, channel 2 in the high byte
	localparam logic [video_pkg::pixel_width-1:0] digit_color [10] = '{
		24'h000000, 24'h800000, 24'hff0000, 24'hffb74c, 24'hffff00,
		24'h008000, 24'h0000ff, 24'h800080, 24'h808080, 24'hffffff
	};

	logic                                 aclk;
	logic                                 aresetn;
	logic [1:0]                           param_mode;
	logic [mnist_pkg::count_width-1:0]    param_th;
	logic [video_pkg::chan_width-1:0]     param_bin_th;
	logic [video_pkg::user_width-1:0]     s_tuser;
	logic                                 s_tlast;
	logic [video_pkg::pixel_width-1:0]    s_tdata;
	logic [mnist_pkg::number_width-1:0]   s_tnumber;
	logic [mnist_pkg::count_width-1:0]    s_tcount;
	logic                                 s_tvalid;
	logic                                 s_tready;
	logic [video_pkg::user_width-1:0]     m_tuser;
	logic                                 m_tlast;
	logic [video_pkg::pixel_width-1:0]    m_tdata;
	logic                                 m_tvalid;
	logic                                 m_tready;

	logic [31:0]                          lfsr_state;
	logic                                 sink_random;	// random m_tready when set
	logic [beat_width-1:0]                exp_q [$];
	logic [video_pkg::user_width-1:0]     exp_tuser;	// queue head, one per edge
	logic                                 exp_tlast;
	logic [video_pkg::pixel_width-1:0]    exp_tdata;
	int                                   exp_count;
	int                                   in_count;
	int                                   out_count;
	int                                   value_errors;
	int                                   protocol_errors;

	video_mnist_color u_dut (
		.aclk, .aresetn, .param_mode, .param_th, .param_bin_th,
		.s_tuser, .s_tlast, .s_tdata, .s_tnumber, .s_tcount, .s_tvalid, .s_tready,
		.m_tuser, .m_tlast, .m_tdata, .m_tvalid, .m_tready
	);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// expected output beat from pixel, label and settings
	function automatic logic [beat_width-1:0] expected_beat(
		input logic [23:0] pix, input logic [3:0] num, input logic [1:0] cnt,
		input logic user, input logic last, input logic [1:0] mode,
		input logic [1:0] th, input logic [7:0] bin_th);
		logic [9:0]  luma_sum;
		logic [7:0]  luma;
		logic [23:0] base;
		luma_sum = pix[7:0] + 2 * pix[15:8] + pix[23:16];
		luma = luma_sum >> 2;
		base = pix;
		if (mode[0]) begin
			base = (luma >= bin_th) ? 24'hffffff : 24'h000000;
		end
		if (mode[1] && cnt >= th && num <= 4'd9) begin
			base = digit_color[num];
		end
		return {user, last, base};
	endfunction

	// one clock step, sink ready driven here too
	task automatic tick();
		logic [31:0] r;
		@(posedge aclk);
		if (sink_random) begin
			take_bits(2, r);
			m_tready <= (r[1:0] != 2'b00);	// about 3 of 4 cycles
		end else begin
			m_tready <= 1'b1;
		end
	endtask

	task automatic send_beat();
		logic [31:0] r;
		take_bits(2, r);
		if (r[1:0] == 2'b00) begin	// idle gap
			s_tvalid <= 1'b0;
			tick();
		end
		take_bits(24, r);
		s_tdata <= r[23:0];
		take_bits(4, r);
		s_tnumber <= r[3:0];
		take_bits(2, r);
		s_tcount <= r[1:0];
		take_bits(2, r);
		s_tuser <= r[0];
		s_tlast <= r[1];
		s_tvalid <= 1'b1;
		do tick(); while (!s_tready);
	endtask

	task automatic run_phase(input logic [1:0] mode, input logic [1:0] th,
		input logic [7:0] bin_th, input logic backpressure);
		tick();
		param_mode   <= mode;	// only changed with the pipeline empty
		param_th     <= th;
		param_bin_th <= bin_th;
		sink_random  = backpressure;
		for (int n = 0; n < beats_per_phase; n++) begin
			send_beat();
		end
		s_tvalid <= 1'b0;
		do tick(); while (exp_count != 0);
	endtask

	// ------------------------------------------------------------
	// expected queue, pushed on input and popped on output
	// ------------------------------------------------------------
	always @(posedge aclk) begin
		if (!aresetn) begin
			exp_q.delete();
		end else begin
			if (m_tvalid && m_tready) begin
				if (exp_q.size() != 0) begin
					void'(exp_q.pop_front());
				end
				out_count++;
			end
			if (s_tvalid && s_tready) begin
				exp_q.push_back(expected_beat(s_tdata, s_tnumber, s_tcount, s_tuser,
					s_tlast, param_mode, param_th, param_bin_th));
				in_count++;
			end
		end
		if (exp_q.size() != 0) begin
			{exp_tuser, exp_tlast, exp_tdata} <= exp_q[0];
		end
		exp_count <= exp_q.size();
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_tdata: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && m_tready) |-> (m_tdata == exp_tdata))
		else begin
			value_errors++;
			$display("[ERROR] m_tdata expected %06h actual %06h",
				$sampled(exp_tdata), $sampled(m_tdata));
		end

	a_tuser: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && m_tready) |-> (m_tuser == exp_tuser))
		else begin
			value_errors++;
			$display("[ERROR] m_tuser expected %0h actual %0h",
				$sampled(exp_tuser), $sampled(m_tuser));
		end

	a_tlast: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && m_tready) |-> (m_tlast == exp_tlast))
		else begin
			value_errors++;
			$display("[ERROR] m_tlast expected %0h actual %0h",
				$sampled(exp_tlast), $sampled(m_tlast));
		end

	a_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && m_tready) |-> (exp_count != 0))
		else begin
			protocol_errors++;
			$display("output beat arrived with no input beat left to match it");
		end

	a_m_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)
			&& $stable(m_tuser) && $stable(m_tlast)))
		else begin
			protocol_errors++;
			$display("output beat changed or vanished while the sink stalled it");
		end

	a_reset_valid: assert property (@(posedge aclk) $past(!aresetn) |-> !m_tvalid)
		else begin
			protocol_errors++;
			$display("m_tvalid was high during or right after reset");
		end

	a_reset_ready: assert property (@(posedge aclk) $rose(aresetn) |-> s_tready)
		else begin
			protocol_errors++;
			$display("s_tready was low in the first cycle after reset");
		end

	// stall guard
	initial begin
		repeat (total_beats * 40) @(posedge aclk);
		$display("watchdog expired, the stream stalled with %0d of %0d beats out",
			out_count, total_beats);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		aresetn = 1'b0;
		param_mode = 2'b00;
		param_th = '0;
		param_bin_th = '0;
		s_tuser = '0;
		s_tlast = 1'b0;
		s_tdata = '0;
		s_tnumber = '0;
		s_tcount = '0;
		s_tvalid = 1'b0;
		m_tready = 1'b0;
		lfsr_state = 32'hc863_16da;
		sink_random = 1'b0;
		in_count = 0;
		out_count = 0;
		value_errors = 0;
		protocol_errors = 0;

		repeat (10) tick();
		aresetn <= 1'b1;

		run_phase(2'b00, 2'd0, 8'h00, 1'b0);	// pass-through
		run_phase(2'b01, 2'd0, 8'h80, 1'b0);	// binary
		run_phase(2'b10, 2'd2, 8'h00, 1'b0);	// overlay on original
		run_phase(2'b11, 2'd1, 8'h40, 1'b0);	// overlay on binary
		run_phase(2'b11, 2'd3, 8'h60, 1'b1);	// back-pressure

		repeat (5) tick();
		if (in_count != total_beats || out_count != total_beats) begin
			protocol_errors++;
			$display("beat count mismatch, %0d sent and %0d received of %0d",
				in_count, out_count, total_beats);
		end
		$display("summary: %0d beats in, %0d beats out, %0d value errors, %0d protocol errors",
			in_count, out_count, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
